// ==== neuron_mem_pkg.sv ====
// neuron status memory package
// widths, depths and word types shared by the status memory blocks

package neuron_mem_pkg;

	// neuron and axon index widths
	localparam int NURN_CNT_WIDTH = 8;
	localparam int AXON_CNT_WIDTH = 8;

	// synapse address is the neuron index above the axon index
	localparam int SYN_ADDR_WIDTH = NURN_CNT_WIDTH + AXON_CNT_WIDTH;

	// weight banks, selected by the top bits of a synapse address
	localparam int BANK_SEL_WIDTH = 2;
	localparam int WEIGHT_BANKS = 1 << BANK_SEL_WIDTH;
	localparam int BANK_ADDR_WIDTH = SYN_ADDR_WIDTH - BANK_SEL_WIDTH;

	// learning queue holds 512 words
	localparam int FIFO_ADDR_WIDTH = 9;

	// fixed point word, 8 integer and 8 fraction bits
	localparam int DATA_INT_WIDTH = 8;
	localparam int DATA_FRAC_WIDTH = 8;
	localparam int STDP_WIN_WIDTH = 8;

	typedef logic [DATA_INT_WIDTH+DATA_FRAC_WIDTH-1:0] status_word_t;

	// spike history window
	typedef logic [STDP_WIN_WIDTH-1:0] stdp_hist_t;

	typedef logic [NURN_CNT_WIDTH-1:0] neuron_addr_t;
	typedef logic [SYN_ADDR_WIDTH-1:0] synapse_addr_t;
	typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;
	typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

endpackage

// ==== status_ram.sv ====
// status memory
// one write port and one read port, read address registered on enable

`timescale 1ns/1ns

module status_ram
	import neuron_mem_pkg::*;
#(
	parameter type payload_t = status_word_t,
	parameter int ADDR_WIDTH = NURN_CNT_WIDTH
)
(
	input  logic                  clk_i,
	input  logic                  rd_en_i,
	input  logic [ADDR_WIDTH-1:0] rd_addr_i,
	input  logic                  wr_en_i,
	input  logic [ADDR_WIDTH-1:0] wr_addr_i,
	input  payload_t              wr_data_i,
	output payload_t              rd_data_o
);

	payload_t mem_q [0:(1 << ADDR_WIDTH)-1];
	logic [ADDR_WIDTH-1:0] rd_addr_q;

	// read address loads only on a read enable
	always_ff @(posedge clk_i)
	begin
		if (rd_en_i)
			rd_addr_q <= rd_addr_i;
		if (wr_en_i)
			mem_q[wr_addr_i] <= wr_data_i;
	end

	// word at the latched address tracks later writes to it
	assign rd_data_o = mem_q[rd_addr_q];

endmodule

// ==== weight_bank_array.sv ====
// weight recall stage
// four weight banks addressed by the top synapse address bits,
// with write and read enables decoded per bank and a registered output select

`timescale 1ns/1ns

module weight_bank_array
	import neuron_mem_pkg::*;
(
	input  logic          clk_i,
	input  logic          rst_n_i,
	input  logic          recall_rd_en_i,
	input  synapse_addr_t recall_rd_addr_i,
	input  logic          weight_wr_en_i,
	input  synapse_addr_t weight_wr_addr_i,
	input  status_word_t  weight_wr_data_i,
	output status_word_t  recall_data_o,
	output logic          recall_valid_o
);

	bank_sel_t rd_sel;
	bank_sel_t wr_sel;
	bank_sel_t rd_sel_q;
	bank_addr_t rd_bank_addr;
	bank_addr_t wr_bank_addr;
	logic [WEIGHT_BANKS-1:0] bank_rd_en;
	logic [WEIGHT_BANKS-1:0] bank_wr_en;
	status_word_t bank_rd_data [WEIGHT_BANKS];
	logic recall_valid_q;

	// split synapse addresses into bank number and word address
	assign rd_sel = recall_rd_addr_i[SYN_ADDR_WIDTH-1 -: BANK_SEL_WIDTH];
	assign wr_sel = weight_wr_addr_i[SYN_ADDR_WIDTH-1 -: BANK_SEL_WIDTH];
	assign rd_bank_addr = recall_rd_addr_i[BANK_ADDR_WIDTH-1:0];
	assign wr_bank_addr = weight_wr_addr_i[BANK_ADDR_WIDTH-1:0];

	// only the addressed bank sees the enables
	always_comb
	begin
		bank_rd_en = '0;
		bank_wr_en = '0;
		bank_rd_en[rd_sel] = recall_rd_en_i;
		bank_wr_en[wr_sel] = weight_wr_en_i;
	end

	for (genvar b = 0; b < WEIGHT_BANKS; b++)
	begin : g_bank
		status_ram #(
			.payload_t  (status_word_t),
			.ADDR_WIDTH (BANK_ADDR_WIDTH)
		) bank_i (
			.clk_i     (clk_i),
			.rd_en_i   (bank_rd_en[b]),
			.rd_addr_i (rd_bank_addr),
			.wr_en_i   (bank_wr_en[b]),
			.wr_addr_i (wr_bank_addr),
			.wr_data_i (weight_wr_data_i),
			.rd_data_o (bank_rd_data[b])
		);
	end

	// bank number sampled every cycle, valid tracks the read enable
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rd_sel_q <= '0;
			recall_valid_q <= 1'b0;
		end
		else
		begin
			rd_sel_q <= rd_sel;
			recall_valid_q <= recall_rd_en_i;
		end
	end

	assign recall_data_o = bank_rd_data[rd_sel_q];
	assign recall_valid_o = recall_valid_q;

endmodule

// ==== weight_fifo.sv ====
// learning queue
// first-word fall-through FIFO for recalled weights, synchronous clear,
// pushes dropped when full and pops ignored when empty

`timescale 1ns/1ns

module weight_fifo
	import neuron_mem_pkg::*;
(
	input  logic         clk_i,
	input  logic         rst_n_i,
	input  logic         clear_i,
	input  logic         push_i,
	input  status_word_t push_data_i,
	input  logic         pop_i,
	output status_word_t head_data_o
);

	status_word_t mem_q [0:(1 << FIFO_ADDR_WIDTH)-1];
	logic [FIFO_ADDR_WIDTH-1:0] wr_ptr_q;
	logic [FIFO_ADDR_WIDTH-1:0] rd_ptr_q;
	logic [FIFO_ADDR_WIDTH:0] count_q;
	logic full;
	logic empty;
	logic push_ok;
	logic pop_ok;

	// count never exceeds the depth, so the top bit alone means full
	assign full = count_q[FIFO_ADDR_WIDTH];
	assign empty = (count_q == '0);

	// clear wins over push and pop in the same cycle
	assign push_ok = push_i && !full && !clear_i;
	assign pop_ok = pop_i && !empty && !clear_i;

	always_ff @(posedge clk_i)
	begin
		if (push_ok)
			mem_q[wr_ptr_q] <= push_data_i;
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else if (clear_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop_ok)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			// simultaneous push and pop keeps the count
			if (push_ok && !pop_ok)
				count_q <= count_q + 1'b1;
			else if (pop_ok && !push_ok)
				count_q <= count_q - 1'b1;
		end
	end

	// head word is undefined while empty
	assign head_data_o = mem_q[rd_ptr_q];

endmodule

// ==== neuron_status_mem.sv ====
// neuron status memory, top level
// per-neuron state memories, pre-synaptic history, banked weight recall
// and the learning queue fed by every recalled weight

`timescale 1ns/1ns

module neuron_status_mem
	import neuron_mem_pkg::*;
(
	input  logic          clk_i,
	input  logic          rst_n_i,
	input  logic          start_i,

	// neuron state, shared addresses
	input  neuron_addr_t  state_rd_addr_i,
	input  neuron_addr_t  state_wr_addr_i,
	input  logic          rd_en_bias_i,
	input  logic          rd_en_potential_i,
	input  logic          rd_en_threshold_i,
	input  logic          rd_en_posthist_i,
	input  logic          wr_en_bias_i,
	input  logic          wr_en_potential_i,
	input  logic          wr_en_threshold_i,
	input  logic          wr_en_posthist_i,
	input  status_word_t  wr_data_bias_i,
	input  status_word_t  wr_data_potential_i,
	input  status_word_t  wr_data_threshold_i,
	input  stdp_hist_t    wr_data_posthist_i,
	output status_word_t  rd_data_bias_o,
	output status_word_t  rd_data_potential_o,
	output status_word_t  rd_data_threshold_o,
	output stdp_hist_t    rd_data_posthist_o,

	// pre-synaptic history
	input  synapse_addr_t prehist_rd_addr_i,
	input  logic          prehist_rd_en_i,
	output stdp_hist_t    prehist_rd_data_o,
	input  synapse_addr_t prehist_wr_addr_i,
	input  logic          prehist_wr_en_i,
	input  stdp_hist_t    prehist_wr_data_i,

	// weight recall and write
	input  synapse_addr_t recall_rd_addr_i,
	input  logic          recall_rd_en_i,
	output status_word_t  recall_rd_data_o,
	input  synapse_addr_t weight_wr_addr_i,
	input  logic          weight_wr_en_i,
	input  status_word_t  weight_wr_data_i,

	// learning queue read side
	input  logic          learn_rd_en_i,
	output status_word_t  learn_rd_data_o
);

	logic recall_valid;

	status_ram #(
		.payload_t  (status_word_t),
		.ADDR_WIDTH (NURN_CNT_WIDTH)
	) bias_ram_i (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_bias_i),
		.rd_addr_i (state_rd_addr_i),
		.wr_en_i   (wr_en_bias_i),
		.wr_addr_i (state_wr_addr_i),
		.wr_data_i (wr_data_bias_i),
		.rd_data_o (rd_data_bias_o)
	);

	status_ram #(
		.payload_t  (status_word_t),
		.ADDR_WIDTH (NURN_CNT_WIDTH)
	) potential_ram_i (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_potential_i),
		.rd_addr_i (state_rd_addr_i),
		.wr_en_i   (wr_en_potential_i),
		.wr_addr_i (state_wr_addr_i),
		.wr_data_i (wr_data_potential_i),
		.rd_data_o (rd_data_potential_o)
	);

	status_ram #(
		.payload_t  (status_word_t),
		.ADDR_WIDTH (NURN_CNT_WIDTH)
	) threshold_ram_i (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_threshold_i),
		.rd_addr_i (state_rd_addr_i),
		.wr_en_i   (wr_en_threshold_i),
		.wr_addr_i (state_wr_addr_i),
		.wr_data_i (wr_data_threshold_i),
		.rd_data_o (rd_data_threshold_o)
	);

	// post-synaptic spike history per neuron
	status_ram #(
		.payload_t  (stdp_hist_t),
		.ADDR_WIDTH (NURN_CNT_WIDTH)
	) posthist_ram_i (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_posthist_i),
		.rd_addr_i (state_rd_addr_i),
		.wr_en_i   (wr_en_posthist_i),
		.wr_addr_i (state_wr_addr_i),
		.wr_data_i (wr_data_posthist_i),
		.rd_data_o (rd_data_posthist_o)
	);

	// pre-synaptic history, one word per synapse
	status_ram #(
		.payload_t  (stdp_hist_t),
		.ADDR_WIDTH (SYN_ADDR_WIDTH)
	) prehist_ram_i (
		.clk_i     (clk_i),
		.rd_en_i   (prehist_rd_en_i),
		.rd_addr_i (prehist_rd_addr_i),
		.wr_en_i   (prehist_wr_en_i),
		.wr_addr_i (prehist_wr_addr_i),
		.wr_data_i (prehist_wr_data_i),
		.rd_data_o (prehist_rd_data_o)
	);

	weight_bank_array weight_banks_i (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.recall_rd_en_i   (recall_rd_en_i),
		.recall_rd_addr_i (recall_rd_addr_i),
		.weight_wr_en_i   (weight_wr_en_i),
		.weight_wr_addr_i (weight_wr_addr_i),
		.weight_wr_data_i (weight_wr_data_i),
		.recall_data_o    (recall_rd_data_o),
		.recall_valid_o   (recall_valid)
	);

	// every recalled weight queued for learning, start empties the queue
	weight_fifo learn_fifo_i (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.clear_i     (start_i),
		.push_i      (recall_valid),
		.push_data_i (recall_rd_data_o),
		.pop_i       (learn_rd_en_i),
		.head_data_o (learn_rd_data_o)
	);

endmodule

// ==== tb_clock_gen.sv ====
// testbench clock and reset source
// free running clock, reset held low for the first few cycles

`timescale 1ns/1ns

module tb_clock_gen
#(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 3
)
(
	output logic clk_o,
	output logic rst_n_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// release on a falling edge away from the sampling edge
	initial
	begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

// ==== neuron_status_mem_props.sv ====
// bound assertions on the neuron status memory
// recall valid timing and hold of the bias read data

`timescale 1ns/1ns

module neuron_status_mem_props
	import neuron_mem_pkg::*;
(
	input logic         clk_i,
	input logic         rst_n_i,
	input logic         recall_rd_en_i,
	input logic         recall_valid_i,
	input logic         rd_en_bias_i,
	input logic         wr_en_bias_i,
	input status_word_t rd_data_bias_i
);

	int fail_cnt = 0;

	// valid is the recall enable one clock later
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		recall_rd_en_i |=> recall_valid_i)
	else
	begin
		fail_cnt++;
		$error("recall valid stayed low after a recall enable");
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!recall_rd_en_i |=> !recall_valid_i)
	else
	begin
		fail_cnt++;
		$error("recall valid rose without a recall enable");
	end

	// first edge out of reset
	assert property (@(posedge clk_i) $rose(rst_n_i) |-> !recall_valid_i)
	else
	begin
		fail_cnt++;
		$error("recall valid high in the cycle after reset");
	end

	// bias output holds with no read and no write
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(!rd_en_bias_i && !wr_en_bias_i && !$isunknown(rd_data_bias_i))
		|=> $stable(rd_data_bias_i))
	else
	begin
		fail_cnt++;
		$error("bias read data changed without a read or a write");
	end

endmodule

bind neuron_status_mem neuron_status_mem_props props_i (
	.clk_i          (clk_i),
	.rst_n_i        (rst_n_i),
	.recall_rd_en_i (recall_rd_en_i),
	.recall_valid_i (recall_valid),
	.rd_en_bias_i   (rd_en_bias_i),
	.wr_en_bias_i   (wr_en_bias_i),
	.rd_data_bias_i (rd_data_bias_o)
);

// ==== neuron_status_mem_tb.sv ====
// testbench for the neuron status memory
// random state, history and weight traffic checked against memory and queue models

`timescale 1ns/1ns

module neuron_status_mem_tb
	import neuron_mem_pkg::*;
();

	localparam int STATE_OPS = 24;
	localparam int PRE_OPS = 24;
	localparam int HOLD_CYCLES = 4;
	localparam int WEIGHT_WORDS = 4 * WEIGHT_BANKS;
	localparam int CLEAR_PRE = 5;
	localparam int CLEAR_POST = 6;
	// all tests with their idle and drain cycles
	localparam int TEST_CYCLES = 3 * STATE_OPS + HOLD_CYCLES + 2 * PRE_OPS
		+ 3 * WEIGHT_WORDS + CLEAR_PRE + 2 * CLEAR_POST + 16;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic clk_i, rst_n_i, start_i;
	neuron_addr_t state_rd_addr_i, state_wr_addr_i;
	logic rd_en_bias_i, rd_en_potential_i, rd_en_threshold_i, rd_en_posthist_i;
	logic wr_en_bias_i, wr_en_potential_i, wr_en_threshold_i, wr_en_posthist_i;
	status_word_t wr_data_bias_i, wr_data_potential_i, wr_data_threshold_i, weight_wr_data_i;
	status_word_t rd_data_bias_o, rd_data_potential_o, rd_data_threshold_o;
	status_word_t recall_rd_data_o, learn_rd_data_o;
	stdp_hist_t wr_data_posthist_i, rd_data_posthist_o, prehist_rd_data_o, prehist_wr_data_i;
	synapse_addr_t prehist_rd_addr_i, prehist_wr_addr_i, recall_rd_addr_i, weight_wr_addr_i;
	logic prehist_rd_en_i, prehist_wr_en_i, recall_rd_en_i, weight_wr_en_i, learn_rd_en_i;
	logic [3:0] state_rd_en;

	// memory and queue models
	status_word_t state_m [3][neuron_addr_t];
	stdp_hist_t post_m [neuron_addr_t];
	stdp_hist_t pre_m [synapse_addr_t];
	status_word_t weight_m [synapse_addr_t];
	status_word_t learn_q [$];
	// registered read addresses as the DUT holds them
	neuron_addr_t state_ra [4];
	bit [3:0] state_rv = '0;
	synapse_addr_t pre_ra = '0;
	synapse_addr_t recall_ra = '0;
	bit pre_rv = 1'b0;
	bit recall_v = 1'b0;
	neuron_addr_t addr_pool [$];
	synapse_addr_t syn_pool [$];
	string test_name = "reset";
	int seed = 96;
	int cycle_cnt = 0;

	assign state_rd_en = {rd_en_posthist_i, rd_en_threshold_i, rd_en_potential_i, rd_en_bias_i};

	tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(3)) clock_gen_i (.clk_o(clk_i), .rst_n_o(rst_n_i));

	neuron_status_mem dut_i (.*);

	function automatic status_word_t state_ref(input int which, input neuron_addr_t a);
		if (state_m[which].exists(a))
			return state_m[which][a];
		return 'x;
	endfunction

	function automatic stdp_hist_t hist_ref(input bit pre, input synapse_addr_t a);
		if (pre)
			return pre_m.exists(a) ? pre_m[a] : 'x;
		return post_m.exists(a[NURN_CNT_WIDTH-1:0]) ? post_m[a[NURN_CNT_WIDTH-1:0]] : 'x;
	endfunction

	function automatic status_word_t weight_ref(input synapse_addr_t a);
		return weight_m.exists(a) ? weight_m[a] : 'x;
	endfunction

	task automatic check_status_word(input string what, input status_word_t exp,
		input status_word_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_hist(input string what, input stdp_hist_t exp, input stdp_hist_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic idle_inputs();
		start_i = 1'b0;
		{rd_en_bias_i, rd_en_potential_i, rd_en_threshold_i, rd_en_posthist_i} = '0;
		{wr_en_bias_i, wr_en_potential_i, wr_en_threshold_i, wr_en_posthist_i} = '0;
		{prehist_rd_en_i, prehist_wr_en_i, recall_rd_en_i, weight_wr_en_i, learn_rd_en_i} = '0;
		{state_rd_addr_i, state_wr_addr_i} = '0;
		{prehist_rd_addr_i, prehist_wr_addr_i, recall_rd_addr_i, weight_wr_addr_i} = '0;
		{wr_data_bias_i, wr_data_potential_i, wr_data_threshold_i, weight_wr_data_i} = '0;
		{wr_data_posthist_i, prehist_wr_data_i} = '0;
	endtask

	task automatic random_state_words();
		wr_data_bias_i = $random(seed);
		wr_data_potential_i = $random(seed);
		wr_data_threshold_i = $random(seed);
		wr_data_posthist_i = $random(seed);
	endtask

	task automatic recall_burst(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(negedge clk_i);
			idle_inputs();
			recall_rd_addr_i = syn_pool[{$random(seed)} % syn_pool.size()];
			recall_rd_en_i = 1'b1;
		end
	endtask

	// waits for the last push, then pops every queued word
	task automatic pop_all();
		int n;
		repeat (2)
		begin
			@(negedge clk_i);
			idle_inputs();
		end
		n = learn_q.size();
		repeat (n)
		begin
			@(negedge clk_i);
			idle_inputs();
			learn_rd_en_i = 1'b1;
		end
		@(negedge clk_i);
		idle_inputs();
	endtask

	initial
	begin : compare
		status_word_t push_word;
		bit was_full;
		@(posedge rst_n_i);
		forever
		begin
			@(posedge clk_i);
			// push carries the word recalled in the previous cycle
			push_word = weight_ref(recall_ra);
			was_full = (learn_q.size() == (1 << FIFO_ADDR_WIDTH));
			if (start_i)
				learn_q.delete();
			else
			begin
				if (learn_rd_en_i && learn_q.size() > 0)
					void'(learn_q.pop_front());
				if (recall_v && !was_full)
					learn_q.push_back(push_word);
			end
			recall_v = recall_rd_en_i;
			if (recall_rd_en_i)
				recall_ra = recall_rd_addr_i;
			if (prehist_rd_en_i)
			begin
				pre_ra = prehist_rd_addr_i;
				pre_rv = 1'b1;
			end
			for (int m = 0; m < 4; m++)
			begin
				if (state_rd_en[m])
				begin
					state_ra[m] = state_rd_addr_i;
					state_rv[m] = 1'b1;
				end
			end
			if (wr_en_bias_i)
				state_m[0][state_wr_addr_i] = wr_data_bias_i;
			if (wr_en_potential_i)
				state_m[1][state_wr_addr_i] = wr_data_potential_i;
			if (wr_en_threshold_i)
				state_m[2][state_wr_addr_i] = wr_data_threshold_i;
			if (wr_en_posthist_i)
				post_m[state_wr_addr_i] = wr_data_posthist_i;
			if (prehist_wr_en_i)
				pre_m[prehist_wr_addr_i] = prehist_wr_data_i;
			if (weight_wr_en_i)
				weight_m[weight_wr_addr_i] = weight_wr_data_i;

			// outputs only move on the rising edge
			@(negedge clk_i);
			if (dut_i.props_i.fail_cnt != 0)
			begin
				$display("a bound assertion on the DUT failed in test %s", test_name);
				$display("Testbench failed");
				$fatal(1);
			end
			if (state_rv[0])
				check_status_word("bias", state_ref(0, state_ra[0]), rd_data_bias_o);
			if (state_rv[1])
				check_status_word("potential", state_ref(1, state_ra[1]), rd_data_potential_o);
			if (state_rv[2])
				check_status_word("threshold", state_ref(2, state_ra[2]), rd_data_threshold_o);
			if (state_rv[3])
				check_hist("posthist", hist_ref(1'b0, synapse_addr_t'(state_ra[3])),
					rd_data_posthist_o);
			if (pre_rv)
				check_hist("prehist", hist_ref(1'b1, pre_ra), prehist_rd_data_o);
			if (recall_v)
				check_status_word("recall", weight_ref(recall_ra), recall_rd_data_o);
			if (learn_q.size() > 0)
				check_status_word("learn head", learn_q[0], learn_rd_data_o);
		end
	end

	initial
	begin : watchdog
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge clk_i);
			cycle_cnt++;
		end
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Testbench failed");
		$fatal(1);
	end

	initial
	begin : stimulus
		bank_addr_t bank_addr;
		idle_inputs();
		@(posedge rst_n_i);

		// fill all four state memories, then rewrite random subsets
		test_name = "neuron_state";
		for (int i = 0; i < 2 * STATE_OPS; i++)
		begin
			@(negedge clk_i);
			idle_inputs();
			random_state_words();
			if (i < STATE_OPS)
			begin
				state_wr_addr_i = $random(seed);
				addr_pool.push_back(state_wr_addr_i);
				{wr_en_bias_i, wr_en_potential_i, wr_en_threshold_i, wr_en_posthist_i} = 4'hf;
			end
			else
			begin
				state_wr_addr_i = addr_pool[{$random(seed)} % addr_pool.size()];
				{wr_en_bias_i, wr_en_potential_i, wr_en_threshold_i, wr_en_posthist_i} =
					4'($random(seed));
			end
		end
		// reads with separate enables and some writes to the same neuron
		for (int i = 0; i < STATE_OPS; i++)
		begin
			@(negedge clk_i);
			idle_inputs();
			random_state_words();
			state_rd_addr_i = addr_pool[{$random(seed)} % addr_pool.size()];
			state_wr_addr_i = state_rd_addr_i;
			{rd_en_posthist_i, rd_en_threshold_i, rd_en_potential_i, rd_en_bias_i} =
				(i == 0) ? 4'hf : 4'($random(seed));
			{wr_en_bias_i, wr_en_potential_i, wr_en_threshold_i, wr_en_posthist_i} =
				4'($random(seed) & $random(seed));
		end
		// outputs hold while the read enables stay low
		for (int i = 0; i < HOLD_CYCLES; i++)
		begin
			@(negedge clk_i);
			idle_inputs();
			state_rd_addr_i = $random(seed);
		end

		test_name = "pre_history";
		for (int i = 0; i < 2 * PRE_OPS; i++)
		begin
			@(negedge clk_i);
			idle_inputs();
			if (i < PRE_OPS)
			begin
				prehist_wr_addr_i = $random(seed);
				prehist_wr_data_i = $random(seed);
				prehist_wr_en_i = 1'b1;
				syn_pool.push_back(prehist_wr_addr_i);
			end
			else
			begin
				prehist_rd_addr_i = syn_pool[{$random(seed)} % syn_pool.size()];
				prehist_rd_en_i = 1'b1;
			end
		end

		// each bank address written in every bank
		test_name = "weight_recall";
		syn_pool.delete();
		for (int i = 0; i < WEIGHT_WORDS; i++)
		begin
			@(negedge clk_i);
			idle_inputs();
			if (i % WEIGHT_BANKS == 0)
				bank_addr = $random(seed);
			weight_wr_addr_i = {bank_sel_t'(i % WEIGHT_BANKS), bank_addr};
			weight_wr_data_i = $random(seed);
			weight_wr_en_i = 1'b1;
			syn_pool.push_back(weight_wr_addr_i);
		end
		recall_burst(WEIGHT_WORDS);

		test_name = "learn_order";
		pop_all();

		// the recall just before start is lost with the cleared queue
		test_name = "clear_on_start";
		recall_burst(CLEAR_PRE);
		@(negedge clk_i);
		idle_inputs();
		start_i = 1'b1;
		recall_burst(CLEAR_POST);
		pop_all();

		@(negedge clk_i);
		if (dut_i.props_i.fail_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
neuron_mem_pkg.sv
status_ram.sv
weight_bank_array.sv
weight_fifo.sv
neuron_status_mem.sv
tb_clock_gen.sv
neuron_status_mem_props.sv
neuron_status_mem_tb.sv

// ==== Bender.yml ====
package:
  name: neuron_status_mem

sources:
  - neuron_mem_pkg.sv
  - status_ram.sv
  - weight_bank_array.sv
  - weight_fifo.sv
  - neuron_status_mem.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - neuron_status_mem_props.sv
      - neuron_status_mem_tb.sv
